//--- mem_subsystem.f
+incdir+verification
common/mem_pkg.sv
design/lsb/load_store_buffer.sv
design/fetch_queue.sv
design/mem_sequencer/mem_sequencer.sv
design/byte_ram.sv
design/mem_subsystem.sv
verification/tb_mem_subsystem.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_mem_subsystem
FILELIST = mem_subsystem.f
BUILD    = obj_dir
PASS     = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(BUILD)

//--- verification/mem_tasks.svh
// dispatch one op; stores update the reference memory.
task automatic dispatch(input mem_pkg::mem_op_e op, input mem_pkg::tag_t tag,
                        input logic [31:0] addr, input logic [31:0] data);
    int n;
    int i;
    n = (op == mem_pkg::sb) ? 1 : (op == mem_pkg::sh) ? 2 : 4;
    if (op inside {mem_pkg::sb, mem_pkg::sh, mem_pkg::sw}) begin
        for (i = 0; i < n; i++) begin
            ref_mem[(addr + 32'(i)) % ram_bytes] = data[8 * i +: 8];
        end
    end
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= '{op, tag, addr, data};
    @(posedge clk);
    req_valid <= 1'b0;
endtask

task automatic commit(input mem_pkg::tag_t tag);
    @(posedge clk);
    commit_valid <= 1'b1;
    commit_tag   <= tag;
    @(posedge clk);
    commit_valid <= 1'b0;
endtask

task automatic fetch(input logic [31:0] fetch_addr);
    @(posedge clk);
    fetch_req <= 1'b1;
    pc        <= fetch_addr;
    @(posedge clk);
    fetch_req <= 1'b0;
endtask

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
        $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        errors++;
        test_errors++;
    end
endtask

task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
        $display("at %0t: %s", $time, what);
        errors++;
        test_errors++;
    end
endtask

task automatic end_test(input string name);
    $display("%s finished with %0d errors", name, test_errors);
    tests_run++;
    test_errors = 0;
endtask

// little-endian word from the reference memory.
function automatic logic [31:0] ref_word(input logic [31:0] addr);
    return {ref_mem[(addr + 32'd3) % ram_bytes], ref_mem[(addr + 32'd2) % ram_bytes],
            ref_mem[(addr + 32'd1) % ram_bytes], ref_mem[addr % ram_bytes]};
endfunction

function automatic logic [31:0] expected_load(input mem_pkg::mem_op_e op,
                                              input logic [31:0] addr);
    logic [31:0] w;
    w = ref_word(addr);
    case (op)
        mem_pkg::lb:  return 32'($signed(w[7:0]));
        mem_pkg::lbu: return 32'(w[7:0]);
        mem_pkg::lh:  return 32'($signed(w[15:0]));
        mem_pkg::lhu: return 32'(w[15:0]);
        default:      return w;
    endcase
endfunction

// waits for the next load result and checks it.
task automatic collect_load(input mem_pkg::mem_op_e op, input mem_pkg::tag_t tag,
                            input logic [31:0] addr);
    mem_pkg::lsb_result_t got;
    while (results.size() == 0) @(posedge clk);
    got = results.pop_front();
    check_value(32'(got.tag), 32'(tag), "result tag");
    check_value(got.value, expected_load(op, addr), op.name());
endtask

task automatic load_check(input mem_pkg::mem_op_e op, input mem_pkg::tag_t tag,
                          input logic [31:0] addr);
    dispatch(op, tag, addr, 32'd0);
    commit(tag);
    collect_load(op, tag, addr);
endtask

// fetched words must come back in request order.
task automatic collect_fetches(input int n, input logic [31:0] base);
    mem_pkg::fetch_out_t got;
    int i;
    while (insns.size() < n) @(posedge clk);
    for (i = 0; i < n; i++) begin
        got = insns.pop_front();
        check_value(got.pc, base + 32'(4 * i), "fetch pc");
        check_value(got.insn, ref_word(base + 32'(4 * i)), "fetch insn");
    end
endtask

//--- verification/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int fq_depth    = 8;
    localparam int ram_bytes   = 1024;
    localparam int cycle_limit = 4000; // about ten times the whole sequence.

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 req_valid;
    mem_pkg::lsb_req_t    req;
    logic                 commit_valid;
    mem_pkg::tag_t        commit_tag;
    logic                 fetch_req;
    logic [31:0]          pc;
    logic                 stall;
    logic                 fq_full;
    logic                 result_valid;
    mem_pkg::lsb_result_t result;
    logic                 store_done;
    mem_pkg::tag_t        store_tag;
    logic                 insn_valid;
    mem_pkg::fetch_out_t  insn;

    logic [7:0]           ref_mem [ram_bytes];
    logic [31:0]          lcg_state = 32'd55;
    mem_pkg::lsb_result_t results [$];
    mem_pkg::tag_t        stores [$];
    mem_pkg::fetch_out_t  insns [$];
    int                   cycles = 0;
    int                   checks = 0;
    int                   errors = 0;
    int                   test_errors = 0;
    int                   tests_run = 0;

    always #5 clk = ~clk;

    mem_subsystem #(
        .fq_depth  (fq_depth),
        .ram_bytes (ram_bytes)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .fetch_req    (fetch_req),
        .pc           (pc),
        .stall        (stall),
        .fq_full      (fq_full),
        .result_valid (result_valid),
        .result       (result),
        .store_done   (store_done),
        .store_tag    (store_tag),
        .insn_valid   (insn_valid),
        .insn         (insn)
    );

    // pulses are caught mid-cycle.
    always @(negedge clk) begin
        if (result_valid) results.push_back(result);
        if (store_done) stores.push_back(store_tag);
        if (insn_valid) insns.push_back(insn);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run hung, no end after %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    `include "mem_tasks.svh"

    task automatic test_store_load();
        logic [31:0] addr;
        logic [31:0] data;
        addr = (next_random() % ram_bytes) & 32'hffff_fffc;
        data = next_random();
        dispatch(mem_pkg::sw, 3'd2, addr, data);
        commit(3'd2);
        while (stores.size() == 0) @(posedge clk);
        check_value(32'(stores.pop_front()), 32'd2, "store tag");
        load_check(mem_pkg::lw, 3'd5, addr);
        end_test("store_load");
    endtask

    task automatic test_extend();
        logic [31:0] addr;
        int k;
        addr = (next_random() % ram_bytes) & 32'hffff_fffc;
        dispatch(mem_pkg::sw, 3'd0, addr, next_random() | 32'h8080_8080);
        commit(3'd0);
        while (stores.size() == 0) @(posedge clk);
        void'(stores.pop_front());
        for (k = 0; k < 4; k++) begin
            load_check(mem_pkg::lb, mem_pkg::tag_t'(k), addr + 32'(k));
            load_check(mem_pkg::lbu, mem_pkg::tag_t'(k + 4), addr + 32'(k));
        end
        for (k = 0; k < 4; k += 2) begin
            load_check(mem_pkg::lh, mem_pkg::tag_t'(k), addr + 32'(k));
            load_check(mem_pkg::lhu, mem_pkg::tag_t'(k + 1), addr + 32'(k));
        end
        end_test("extend");
    endtask

    task automatic test_uncommitted();
        logic [31:0] addr;
        addr = (next_random() % ram_bytes) & 32'hffff_fffc;
        dispatch(mem_pkg::lw, 3'd6, addr, 32'd0);
        repeat (50) @(posedge clk);
        check_true(results.size() == 0, "a load completed before its commit");
        commit(3'd6);
        collect_load(mem_pkg::lw, 3'd6, addr);
        end_test("uncommitted");
    endtask

    task automatic test_fetch_with_loads();
        int i;
        for (i = 0; i < fq_depth; i++) begin
            dispatch(mem_pkg::sw, mem_pkg::tag_t'(i), 32'h100 + 32'(4 * i), next_random());
            commit(mem_pkg::tag_t'(i));
        end
        while (stores.size() < fq_depth) @(posedge clk);
        for (i = 0; i < fq_depth; i++) begin
            check_value(32'(stores.pop_front()), 32'(i), "store order");
        end
        dispatch(mem_pkg::lw, 3'd4, 32'h100, 32'd0);
        dispatch(mem_pkg::lw, 3'd5, 32'h104, 32'd0);
        fork
            begin
                for (i = 0; i < 4; i++) fetch(32'h100 + 32'(4 * i));
            end
            begin
                commit(3'd4);
                commit(3'd5);
            end
        join
        collect_load(mem_pkg::lw, 3'd4, 32'h100);
        collect_load(mem_pkg::lw, 3'd5, 32'h104);
        collect_fetches(4, 32'h100);
        end_test("fetch_with_loads");
    endtask

    task automatic test_stall_full();
        int i;
        @(posedge clk);
        stall <= 1'b1;
        for (i = 0; i < fq_depth; i++) begin
            fetch(32'h100 + 32'(4 * i));
        end
        repeat (20) @(posedge clk);
        @(negedge clk);
        check_value(32'(fq_full), 32'd1, "fq_full");
        check_true(insns.size() == 0, "an instruction came back while stalled");
        @(posedge clk);
        stall <= 1'b0;
        collect_fetches(fq_depth, 32'h100);
        end_test("stall_full");
    endtask

    initial begin
        rst          = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        commit_valid = 1'b0;
        commit_tag   = '0;
        fetch_req    = 1'b0;
        pc           = '0;
        stall        = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        test_store_load();
        test_extend();
        test_uncommitted();
        test_fetch_with_loads();
        test_stall_full();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- design/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int fq_depth  = 8,
    parameter int ram_bytes = 1024
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  mem_pkg::lsb_req_t     req,
    input  logic                  commit_valid,
    input  mem_pkg::tag_t         commit_tag,
    input  logic                  fetch_req,
    input  logic [31:0]           pc,
    input  logic                  stall,
    output logic                  fq_full,
    output logic                  result_valid,
    output mem_pkg::lsb_result_t  result,
    output logic                  store_done,
    output mem_pkg::tag_t         store_tag,
    output logic                  insn_valid,
    output mem_pkg::fetch_out_t   insn
);

    logic              job_valid;
    mem_pkg::mem_job_t job;
    logic              job_take;
    logic              fetch_valid;
    logic [31:0]       fetch_pc;
    logic              fetch_take;
    logic [31:0]       ram_addr;
    logic              ram_we;
    logic [7:0]        ram_wdata;
    logic [7:0]        ram_rdata;

    load_store_buffer u_lsb (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .job_take     (job_take),
        .job_valid    (job_valid),
        .job          (job)
    );

    fetch_queue #(
        .fq_depth (fq_depth)
    ) u_fq (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .pc          (pc),
        .fetch_take  (fetch_take),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fq_full     (fq_full)
    );

    mem_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .job_valid    (job_valid),
        .job          (job),
        .job_take     (job_take),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_take   (fetch_take),
        .ram_addr     (ram_addr),
        .ram_we       (ram_we),
        .ram_wdata    (ram_wdata),
        .ram_rdata    (ram_rdata),
        .result_valid (result_valid),
        .result       (result),
        .store_done   (store_done),
        .store_tag    (store_tag),
        .insn_valid   (insn_valid),
        .insn         (insn)
    );

    byte_ram #(
        .ram_bytes (ram_bytes)
    ) u_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

//--- design/byte_ram.sv
`timescale 1ns/1ps

module byte_ram #(
    parameter int ram_bytes = 1024
) (
    input  logic        clk,
    input  logic [31:0] addr,
    input  logic        we,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata
);

    logic [7:0]  mem_q [ram_bytes];
    logic [31:0] idx;

    assign idx = addr % ram_bytes; // addresses wrap.

    always_ff @(posedge clk) begin
        if (we) begin
            mem_q[idx] <= wdata;
        end
        rdata <= mem_q[idx]; // read-first.
    end

endmodule

//--- design/mem_sequencer/mem_sequencer.sv
`timescale 1ns/1ps

module mem_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  job_valid,
    input  mem_pkg::mem_job_t     job,
    output logic                  job_take,
    input  logic                  fetch_valid,
    input  logic [31:0]           fetch_pc,
    output logic                  fetch_take,
    output logic [31:0]           ram_addr,
    output logic                  ram_we,
    output logic [7:0]            ram_wdata,
    input  logic [7:0]            ram_rdata,
    output logic                  result_valid,
    output mem_pkg::lsb_result_t  result,
    output logic                  store_done,
    output mem_pkg::tag_t         store_tag,
    output logic                  insn_valid,
    output mem_pkg::fetch_out_t   insn
);

    typedef enum logic [1:0] {
        idle,
        issue,
        drain,
        finish
    } seq_state_e;

    seq_state_e        state;
    mem_pkg::mem_job_t cur_q;
    mem_pkg::mem_job_t fetch_job;
    logic [1:0]        cnt;
    logic [3:0][7:0]   word_q; // little-endian byte lanes.
    logic [1:0]        last_idx;
    logic              is_store;

    // index of the last byte of an access.
    function automatic logic [1:0] last_byte(mem_pkg::mem_op_e op);
        case (op)
            mem_pkg::lb, mem_pkg::lbu, mem_pkg::sb: return 2'd0;
            mem_pkg::lh, mem_pkg::lhu, mem_pkg::sh: return 2'd1;
            default:                                return 2'd3;
        endcase
    endfunction

    function automatic logic [31:0] extend(mem_pkg::mem_op_e op, logic [31:0] w);
        case (op)
            mem_pkg::lb:  return {{24{w[7]}}, w[7:0]};
            mem_pkg::lbu: return {24'h0, w[7:0]};
            mem_pkg::lh:  return {{16{w[15]}}, w[15:0]};
            mem_pkg::lhu: return {16'h0, w[15:0]};
            default:      return w;
        endcase
    endfunction

    assign last_idx = last_byte(cur_q.op);
    assign is_store = cur_q.op inside {mem_pkg::sb, mem_pkg::sh, mem_pkg::sw};

    // committed buffer work beats fetch.
    assign job_take   = (state == idle) && !stall && job_valid;
    assign fetch_take = (state == idle) && !stall && !job_valid && fetch_valid;

    always_comb begin
        fetch_job.op       = mem_pkg::lw;
        fetch_job.tag      = '0;
        fetch_job.addr     = fetch_pc;
        fetch_job.data     = '0;
        fetch_job.is_fetch = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (job_take || fetch_take) begin
                        state <= issue;
                        cnt   <= '0;
                    end
                end
                issue: begin
                    if (cnt == last_idx) begin
                        state <= is_store ? finish : drain; // stores skip the read drain.
                    end else begin
                        cnt <= cnt + 2'd1;
                    end
                end
                drain:   state <= finish;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (job_take) begin
            cur_q <= job;
        end else if (fetch_take) begin
            cur_q <= fetch_job;
        end
        // read data lags its address by one cycle.
        if (state == issue && cnt != 2'd0) begin
            word_q[cnt - 2'd1] <= ram_rdata;
        end
        if (state == drain) begin
            word_q[cnt] <= ram_rdata;
        end
    end

    assign ram_addr  = cur_q.addr + {30'd0, cnt};
    assign ram_we    = (state == issue) && is_store;
    assign ram_wdata = cur_q.data[{cnt, 3'b000} +: 8];

    assign result_valid = (state == finish) && !cur_q.is_fetch && !is_store;
    assign result.tag   = cur_q.tag;
    assign result.value = extend(cur_q.op, word_q);

    assign store_done = (state == finish) && is_store;
    assign store_tag  = cur_q.tag;

    assign insn_valid = (state == finish) && cur_q.is_fetch;
    assign insn.pc    = cur_q.addr;
    assign insn.insn  = word_q;

    // a taken load or fetch writes no byte in its issue cycles.
    a_we_store_only: assert property (@(posedge clk) disable iff (!rst)
        (fetch_take
            || (job_take && !(job.op inside {mem_pkg::sb, mem_pkg::sh, mem_pkg::sw})))
        |=> !ram_we ##1 !ram_we ##1 !ram_we ##1 !ram_we);

endmodule

//--- design/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
    parameter int fq_depth = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_req,
    input  logic [31:0] pc,
    input  logic        fetch_take,
    output logic        fetch_valid,
    output logic [31:0] fetch_pc,
    output logic        fq_full
);

    localparam int pw = $clog2(fq_depth);

    logic [pw-1:0] head;
    logic [pw-1:0] tail;
    logic [pw:0]   count;
    logic [31:0]   pc_q [fq_depth];
    logic          push;
    logic          pop;

    assign fq_full     = count == (pw + 1)'(fq_depth);
    assign fetch_valid = count != '0;
    assign fetch_pc    = pc_q[head];

    assign push = fetch_req && !fq_full; // dropped when full.
    assign pop  = fetch_take && fetch_valid;

    always_ff @(posedge clk) begin
        if (!rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_q[tail] <= pc;
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst)
        fetch_req |-> !fq_full);

endmodule

//--- design/lsb/load_store_buffer.sv
`timescale 1ns/1ps

module load_store_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  mem_pkg::lsb_req_t    req,
    input  logic                 commit_valid,
    input  mem_pkg::tag_t        commit_tag,
    input  logic                 job_take,
    output logic                 job_valid,
    output mem_pkg::mem_job_t    job
);

    localparam int slots = 1 << mem_pkg::tag_w;

    logic [slots-1:0] busy;
    logic [slots-1:0] committed;
    mem_pkg::mem_op_e op_q [slots];
    logic [31:0]      addr_q [slots];
    logic [31:0]      data_q [slots];
    mem_pkg::tag_t    sel_tag;

    // lowest committed slot wins.
    always_comb begin
        sel_tag = '0;
        for (int i = slots - 1; i >= 0; i--) begin
            if (busy[i] && committed[i]) begin
                sel_tag = mem_pkg::tag_t'(i);
            end
        end
    end

    assign job_valid = |(busy & committed);

    always_comb begin
        job.op       = op_q[sel_tag];
        job.tag      = sel_tag;
        job.addr     = addr_q[sel_tag];
        job.data     = data_q[sel_tag];
        job.is_fetch = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy      <= '0;
            committed <= '0;
        end else begin
            if (job_take) begin
                busy[sel_tag]      <= 1'b0; // slot freed on take.
                committed[sel_tag] <= 1'b0;
            end
            if (commit_valid) begin
                committed[commit_tag] <= 1'b1;
            end
            if (req_valid) begin
                busy[req.tag]      <= 1'b1;
                committed[req.tag] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            op_q[req.tag]   <= req.op;
            addr_q[req.tag] <= req.addr;
            data_q[req.tag] <= req.data;
        end
    end

    // rob must not reuse a tag before its memory op completes.
    a_dispatch_free: assert property (@(posedge clk) disable iff (!rst)
        req_valid |-> !busy[req.tag]);

    // commit only for a dispatched, not yet committed tag.
    a_commit_busy: assert property (@(posedge clk) disable iff (!rst)
        commit_valid |-> busy[commit_tag] && !committed[commit_tag]);

endmodule

//--- common/mem_pkg.sv
package mem_pkg;

    // reorder buffer size is fixed by the core.
    parameter int tag_w = 3;

    typedef logic [tag_w-1:0] tag_t;

    typedef enum logic [2:0] {
        lb,
        lh,
        lw,
        lbu,
        lhu,
        sb,
        sh,
        sw
    } mem_op_e;

    // dispatch request into the load/store buffer.
    typedef struct packed {
        mem_op_e     op;
        tag_t        tag;
        logic [31:0] addr;
        logic [31:0] data; // store value.
    } lsb_req_t;

    // one unit of work for the sequencer.
    typedef struct packed {
        mem_op_e     op;
        tag_t        tag;
        logic [31:0] addr;
        logic [31:0] data;
        logic        is_fetch;
    } mem_job_t;

    typedef struct packed {
        tag_t        tag;
        logic [31:0] value; // already extended.
    } lsb_result_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] insn;
    } fetch_out_t;

endpackage
